/* filelist.f */
+incdir+.
csr_pkg.sv
csr_counter.sv
csr_timer.sv
csr_decode.sv
csr_file.sv
csr_exec.sv
csr_top.sv
csr_assert.sv
tb_csr.sv

/* Makefile */
# Verilator flow for the CSR pipeline testbench.

TOP := tb_csr

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) \
		-Mdir obj_dir -o V$(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F "Finished with no errors"

clean:
	rm -rf obj_dir

/* tb_csr.sv */
`timescale 1ns/100ps
`default_nettype none
`include "csr_cfg.svh"

module tb_csr;

   import csr_pkg::*;

   localparam int PERIOD = 20;

   // Worst-case cycle budget of each test.
   localparam int RESET_CYC   = 8;
   localparam int USTATUS_CYC = 12 * 3;
   localparam int CYCLE_CYC   = 3 * (6 + 15) + 3;
   localparam int INSTRET_CYC = 3 * (9 + 2 * 8) + 3;
   localparam int TIME_CYC    = 4 * (6 + 15) + 3;
   localparam int ILLEGAL_CYC = 6 * 3;
   localparam int B2B_CYC     = 8;
   localparam int MARGIN_CYC  = 50;
   localparam int WATCHDOG_NS = PERIOD * (RESET_CYC + USTATUS_CYC + CYCLE_CYC + INSTRET_CYC +
                                          TIME_CYC + ILLEGAL_CYC + B2B_CYC + MARGIN_CYC);

   logic        clk;
   logic        rst_n;
   csr_req_t    req;
   logic        retire;
   csr_rsp_t    rsp;

   logic [31:0] lfsr_state = 32'hbea62d4f;
   logic [31:0] ustatus_model;
   logic [31:0] retire_model;
   logic [31:0] cycle_count;

   csr_top u_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .req_i    (req),
      .retire_i (retire),
      .rsp_o    (rsp)
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Edges seen since reset release.
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cycle_count <= 32'd0;
      end else begin
         cycle_count <= cycle_count + 32'd1;
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before the tests completed.");
      $display("Finished with errors");
      $fatal(1, "run stopped by watchdog");
   end

   // --------------------
   // Helpers
   // --------------------
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          i;
      v = 32'd0;
      for (i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
      end
      return v;
   endfunction

   function automatic csr_op_e rand_op();
      logic [31:0] b;
      b = rand_bits(2);
      case (b[1:0])
         2'd1:    return CSR_OP_RS;
         2'd2:    return CSR_OP_RC;
         default: return CSR_OP_RW;
      endcase
   endfunction

   // Reference rule for the new register value.
   function automatic logic [31:0] next_value(input csr_op_e op, input logic [31:0] old,
                                              input logic [31:0] operand);
      case (op)
         CSR_OP_RS: return old | operand;
         CSR_OP_RC: return old & ~operand;
         default:   return operand;
      endcase
   endfunction

   task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch at time %0t: %s got %h expected %h", $time, what, got, exp);
         $display("Finished with errors");
         $fatal(1, "stopping at first error");
      end
   endtask

   task automatic wait_cycles(input logic [31:0] n);
      repeat (n) @(negedge clk);
   endtask

   task automatic drive_req(input csr_op_e op, input logic [11:0] addr,
                            input logic [31:0] operand);
      req.valid   = 1'b1;
      req.op      = op;
      req.addr    = addr;
      req.operand = operand;
   endtask

   // Idle cycles keep a stale write on the bus that must not land.
   task automatic drop_req();
      req.valid   = 1'b0;
      req.operand = ~req.operand;
   endtask

   // One request; the response is taken two edges later.
   task automatic access(input csr_op_e op, input logic [11:0] addr, input logic [31:0] operand,
                         output csr_rsp_t got, output logic [31:0] stamp);
      @(negedge clk);
      drive_req(op, addr, operand);
      stamp = cycle_count;
      @(negedge clk);
      drop_req();
      @(negedge clk);
      got = rsp;
      check_eq("response valid", 32'(got.valid), 32'h1);
   endtask

   task automatic pulse_retire(input logic [31:0] n);
      repeat (n) begin
         @(negedge clk);
         retire = 1'b1;
         @(negedge clk);
         retire = 1'b0;
         retire_model = retire_model + 32'd1;
      end
   endtask

   // --------------------
   // Tests
   // --------------------
   task automatic ustatus_rmw();
      csr_rsp_t    got;
      csr_op_e     op;
      logic [31:0] operand;
      logic [31:0] stamp;
      int          i;
      for (i = 0; i < 12; i++) begin
         op = rand_op();
         operand = (i == 5) ? 32'h0 : rand_bits(32);
         access(op, ADDR_USTATUS, operand, got, stamp);
         check_eq("ustatus legal", 32'(got.illegal), 32'h0);
         check_eq("ustatus old value", got.rdata, ustatus_model);
         ustatus_model = next_value(op, ustatus_model, operand);
      end
   endtask

   task automatic cycle_reads();
      csr_rsp_t    first;
      csr_rsp_t    second;
      logic [31:0] s1;
      logic [31:0] s2;
      int          i;
      for (i = 0; i < 3; i++) begin
         access(CSR_OP_RS, ADDR_CYCLE, 32'h0, first, s1);
         wait_cycles(rand_bits(4));
         access(CSR_OP_RS, ADDR_CYCLE, 32'h0, second, s2);
         check_eq("cycle legal", 32'(second.illegal), 32'h0);
         check_eq("cycle step", second.rdata - first.rdata, s2 - s1);
      end
      access(CSR_OP_RC, ADDR_CYCLEH, 32'h0, first, s1);
      check_eq("cycleh", first.rdata, 32'h0);
   endtask

   task automatic instret_reads();
      csr_rsp_t    first;
      csr_rsp_t    second;
      csr_rsp_t    third;
      logic [31:0] s;
      logic [31:0] n;
      int          i;
      for (i = 0; i < 3; i++) begin
         access(CSR_OP_RS, ADDR_INSTRET, 32'h0, first, s);
         check_eq("instret value", first.rdata, retire_model);
         n = rand_bits(3) + 32'd1;
         pulse_retire(n);
         access(CSR_OP_RS, ADDR_INSTRET, 32'h0, second, s);
         check_eq("instret step", second.rdata - first.rdata, n);
         access(CSR_OP_RC, ADDR_INSTRET, 32'h0, third, s);
         check_eq("instret without retire", third.rdata, second.rdata);
      end
      access(CSR_OP_RS, ADDR_INSTRETH, 32'h0, first, s);
      check_eq("instreth", first.rdata, 32'h0);
   endtask

   task automatic time_reads();
      csr_rsp_t    first;
      csr_rsp_t    second;
      logic [31:0] s1;
      logic [31:0] s2;
      logic [31:0] lo;
      logic [31:0] d;
      int          i;
      for (i = 0; i < 4; i++) begin
         access(CSR_OP_RS, ADDR_TIME, 32'h0, first, s1);
         wait_cycles(rand_bits(4));
         access(CSR_OP_RS, ADDR_TIME, 32'h0, second, s2);
         lo = (s2 - s1) / 32'(`CSR_TIMER_DIV);
         d  = second.rdata - first.rdata;
         check_eq("time step in range", 32'((d == lo) || (d == lo + 32'd1)), 32'h1);
      end
      access(CSR_OP_RS, ADDR_TIMEH, 32'h0, first, s1);
      check_eq("timeh", first.rdata, 32'h0);
   endtask

   task automatic illegal_access();
      csr_rsp_t    base;
      csr_rsp_t    got;
      logic [31:0] s1;
      logic [31:0] s2;
      access(CSR_OP_RS, ADDR_CYCLE, 32'h0, base, s1);
      check_eq("cycle read-set zero legal", 32'(base.illegal), 32'h0);
      access(CSR_OP_RW, ADDR_CYCLE, rand_bits(32), got, s2);
      check_eq("cycle write illegal", 32'(got.illegal), 32'h1);
      check_eq("cycle write rdata", got.rdata, 32'h0);
      access(CSR_OP_RS, ADDR_CYCLEH, 32'h1, got, s2);
      check_eq("cycleh set illegal", 32'(got.illegal), 32'h1);
      access(CSR_OP_RS, 12'hC03, 32'h0, got, s2);
      check_eq("unknown read illegal", 32'(got.illegal), 32'h1);
      check_eq("unknown read rdata", got.rdata, 32'h0);
      access(CSR_OP_RW, 12'h7C0, rand_bits(32), got, s2);
      check_eq("unknown write illegal", 32'(got.illegal), 32'h1);
      check_eq("unknown write rdata", got.rdata, 32'h0);
      access(CSR_OP_RC, ADDR_CYCLE, 32'h0, got, s2);
      check_eq("cycle read-clear zero legal", 32'(got.illegal), 32'h0);
      check_eq("cycle undisturbed", got.rdata - base.rdata, s2 - s1);
   endtask

   // Four requests on consecutive cycles.
   task automatic back_to_back();
      logic [31:0] exp_q[$];
      csr_op_e     op;
      logic [31:0] operand;
      int          i;
      for (i = 0; i < 6; i++) begin
         @(negedge clk);
         if (i >= 2) begin
            check_eq("pipelined valid", 32'(rsp.valid), 32'h1);
            check_eq("pipelined legal", 32'(rsp.illegal), 32'h0);
            check_eq("pipelined old value", rsp.rdata, exp_q.pop_front());
         end
         if (i < 4) begin
            op = rand_op();
            operand = rand_bits(32);
            drive_req(op, ADDR_USTATUS, operand);
            exp_q.push_back(ustatus_model);
            ustatus_model = next_value(op, ustatus_model, operand);
         end else if (i == 4) begin
            drop_req();
         end
      end
      @(negedge clk);
      check_eq("pipeline drained", 32'(rsp.valid), 32'h0);
   endtask

   initial begin
      rst_n         = 1'b0;
      req           = '0;
      retire        = 1'b0;
      ustatus_model = 32'd0;
      retire_model  = 32'd0;
      repeat (RESET_CYC) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      ustatus_rmw();
      cycle_reads();
      instret_reads();
      time_reads();
      illegal_access();
      back_to_back();

      @(negedge clk);
      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

/* csr_assert.sv */
`timescale 1ns/100ps
`default_nettype none
`include "csr_cfg.svh"

module csr_assert (
   input wire                     clk,
   input wire                     rst_n,
   input wire csr_pkg::csr_req_t  req_i,
   input wire csr_pkg::csr_rsp_t  rsp_i
);

   // --------------------
   // Pipeline latency
   // --------------------
   property p_latency;
      @(posedge clk) disable iff (!rst_n)
         rsp_i.valid == $past(req_i.valid, 2);
   endproperty

   a_latency: assert property (p_latency)
      else $error("response valid does not follow request valid by two cycles");

   // Quiet while in reset.
   a_reset: assert property (@(posedge clk) !rst_n |-> !rsp_i.valid)
      else $error("response valid seen during reset");

   // Illegal requests return zero.
   a_illegal: assert property (@(posedge clk) disable iff (!rst_n)
                               (rsp_i.valid && rsp_i.illegal) |-> (rsp_i.rdata == '0))
      else $error("illegal response carries nonzero read data");

endmodule

bind csr_top csr_assert u_assert (
   .clk   (clk),
   .rst_n (rst_n),
   .req_i (req_i),
   .rsp_i (rsp_o)
);

`default_nettype wire

/* csr_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "csr_cfg.svh"

module csr_top (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire csr_pkg::csr_req_t  req_i,
   input  wire                     retire_i,
   output csr_pkg::csr_rsp_t       rsp_o
);

   import csr_pkg::*;

   csr_dec_t                   dec;
   csr_sel_e                   sel;
   logic                       we;
   logic [`CSR_DATA_WIDTH-1:0] wdata;
   logic [`CSR_DATA_WIDTH-1:0] rdata;

   // --------------------
   // Decode stage
   // --------------------
   csr_decode u_decode (
      .clk   (clk),
      .rst_n (rst_n),
      .req_i (req_i),
      .dec_o (dec)
   );

   // --------------------
   // Execute stage
   // --------------------
   csr_exec u_exec (
      .clk     (clk),
      .rst_n   (rst_n),
      .dec_i   (dec),
      .rdata_i (rdata),
      .sel_o   (sel),
      .we_o    (we),
      .wdata_o (wdata),
      .rsp_o   (rsp_o)
   );

   csr_file u_file (
      .clk      (clk),
      .rst_n    (rst_n),
      .retire_i (retire_i),
      .sel_i    (sel),
      .we_i     (we),
      .wdata_i  (wdata),
      .rdata_o  (rdata)
   );

endmodule

`default_nettype wire

/* csr_exec.sv */
`timescale 1ns/100ps
`default_nettype none
`include "csr_cfg.svh"

module csr_exec (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire csr_pkg::csr_dec_t      dec_i,
   input  wire [`CSR_DATA_WIDTH-1:0]   rdata_i,
   output csr_pkg::csr_sel_e           sel_o,
   output logic                        we_o,
   output logic [`CSR_DATA_WIDTH-1:0]  wdata_o,
   output csr_pkg::csr_rsp_t           rsp_o
);

   import csr_pkg::*;

   logic                       rsp_valid_q;
   logic                       rsp_illegal_q;
   logic [`CSR_DATA_WIDTH-1:0] rsp_rdata_q;

   // --------------------
   // Read-modify-write
   // --------------------
   assign sel_o = dec_i.sel;
   assign we_o  = dec_i.valid && dec_i.we;

   always_comb begin
      case (dec_i.op)
         CSR_OP_RS: wdata_o = rdata_i | dec_i.operand;
         CSR_OP_RC: wdata_o = rdata_i & ~dec_i.operand;
         default:   wdata_o = dec_i.operand;
      endcase
   end

   // --------------------
   // Response
   // --------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rsp_valid_q   <= 1'b0;
         rsp_illegal_q <= 1'b0;
      end else begin
         rsp_valid_q   <= dec_i.valid;
         rsp_illegal_q <= dec_i.illegal;
      end
   end

   // Illegal requests return zero.
   always_ff @(posedge clk) begin
      rsp_rdata_q <= dec_i.illegal ? '0 : rdata_i;
   end

   assign rsp_o = '{valid: rsp_valid_q, illegal: rsp_illegal_q, rdata: rsp_rdata_q};

endmodule

`default_nettype wire

/* csr_file.sv */
`timescale 1ns/100ps
`default_nettype none
`include "csr_cfg.svh"

module csr_file (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire                         retire_i,
   input  wire csr_pkg::csr_sel_e      sel_i,
   input  wire                         we_i,
   input  wire [`CSR_DATA_WIDTH-1:0]   wdata_i,
   output logic [`CSR_DATA_WIDTH-1:0]  rdata_o
);

   import csr_pkg::*;

   csr_cnt_u                   cycle_cnt;
   csr_cnt_u                   time_cnt;
   csr_cnt_u                   instret_cnt;
   logic [`CSR_DATA_WIDTH-1:0] ustatus_q;

   // --------------------
   // Counters
   // --------------------
   csr_counter u_cycle (
      .clk   (clk),
      .rst_n (rst_n),
      .inc_i (1'b1),
      .val_o (cycle_cnt.word)
   );

   csr_counter u_instret (
      .clk   (clk),
      .rst_n (rst_n),
      .inc_i (retire_i),
      .val_o (instret_cnt.word)
   );

   csr_timer u_timer (
      .clk   (clk),
      .rst_n (rst_n),
      .val_o (time_cnt.word)
   );

   // User status register.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ustatus_q <= '0;
      end else if (we_i && (sel_i == SEL_USTATUS)) begin
         ustatus_q <= wdata_i;
      end
   end

   // Read port returns the value held before the edge.
   always_comb begin
      case (sel_i)
         SEL_CYCLE:    rdata_o = cycle_cnt.half.lo;
         SEL_CYCLEH:   rdata_o = cycle_cnt.half.hi;
         SEL_TIME:     rdata_o = time_cnt.half.lo;
         SEL_TIMEH:    rdata_o = time_cnt.half.hi;
         SEL_INSTRET:  rdata_o = instret_cnt.half.lo;
         SEL_INSTRETH: rdata_o = instret_cnt.half.hi;
         SEL_USTATUS:  rdata_o = ustatus_q;
         default:      rdata_o = '0;
      endcase
   end

endmodule

`default_nettype wire

/* csr_decode.sv */
`timescale 1ns/100ps
`default_nettype none
`include "csr_cfg.svh"

module csr_decode (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire csr_pkg::csr_req_t  req_i,
   output csr_pkg::csr_dec_t       dec_o
);

   import csr_pkg::*;

   csr_sel_e                   sel;
   logic                       unknown;
   logic                       is_cnt;
   logic                       wr;
   logic                       illegal;

   logic                       valid_q;
   logic                       we_q;
   logic                       illegal_q;
   csr_op_e                    op_q;
   csr_sel_e                   sel_q;
   logic [`CSR_DATA_WIDTH-1:0] operand_q;

   // --------------------
   // Address decode
   // --------------------
   always_comb begin
      unknown = 1'b0;
      case (req_i.addr)
         ADDR_CYCLE:    sel = SEL_CYCLE;
         ADDR_CYCLEH:   sel = SEL_CYCLEH;
         ADDR_TIME:     sel = SEL_TIME;
         ADDR_TIMEH:    sel = SEL_TIMEH;
         ADDR_INSTRET:  sel = SEL_INSTRET;
         ADDR_INSTRETH: sel = SEL_INSTRETH;
         ADDR_USTATUS:  sel = SEL_USTATUS;
         default: begin
            sel     = SEL_NONE;
            unknown = 1'b1;
         end
      endcase
   end

   // Set and clear with a zero operand are pure reads.
   assign wr = ((req_i.op == CSR_OP_RS) || (req_i.op == CSR_OP_RC)) ?
               (req_i.operand != '0) : 1'b1;

   assign is_cnt  = (sel != SEL_USTATUS) && (sel != SEL_NONE);
   assign illegal = unknown || (is_cnt && wr);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q   <= 1'b0;
         we_q      <= 1'b0;
         illegal_q <= 1'b0;
      end else begin
         valid_q   <= req_i.valid;
         we_q      <= wr && !illegal;
         illegal_q <= illegal;
      end
   end

   always_ff @(posedge clk) begin
      op_q      <= req_i.op;
      sel_q     <= sel;
      operand_q <= req_i.operand;
   end

   assign dec_o = '{valid: valid_q, op: op_q, sel: sel_q, we: we_q,
                    illegal: illegal_q, operand: operand_q};

endmodule

`default_nettype wire

/* csr_timer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "csr_cfg.svh"

module csr_timer (
   input  wire                  clk,
   input  wire                  rst_n,
   output logic [`CSR_XLEN-1:0] val_o
);

   import csr_pkg::*;

   logic [CSR_PRE_WIDTH-1:0] pre_q;
   logic                     tick;

   // Wrap of the prescaler steps the count.
   assign tick = (pre_q == CSR_PRE_MAX);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pre_q <= '0;
      end else if (tick) begin
         pre_q <= '0;
      end else begin
         pre_q <= pre_q + 1'b1;
      end
   end

   csr_counter u_count (
      .clk   (clk),
      .rst_n (rst_n),
      .inc_i (tick),
      .val_o (val_o)
   );

endmodule

`default_nettype wire

/* csr_counter.sv */
`timescale 1ns/100ps
`default_nettype none
`include "csr_cfg.svh"

module csr_counter (
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire                  inc_i,
   output logic [`CSR_XLEN-1:0] val_o
);

   // Count steps only when the caller asks.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         val_o <= '0;
      end else if (inc_i) begin
         val_o <= val_o + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* csr_pkg.sv */
`default_nettype none
`include "csr_cfg.svh"

package csr_pkg;

   // --------------------
   // Operations and selects
   // --------------------
   typedef enum logic [1:0] {
      CSR_OP_RW = 2'd1,
      CSR_OP_RS = 2'd2,
      CSR_OP_RC = 2'd3
   } csr_op_e;

   typedef enum logic [2:0] {
      SEL_CYCLE, SEL_CYCLEH, SEL_TIME, SEL_TIMEH,
      SEL_INSTRET, SEL_INSTRETH, SEL_USTATUS, SEL_NONE
   } csr_sel_e;

   // User CSR map.
   localparam logic [`CSR_ADDR_WIDTH-1:0] ADDR_USTATUS  = 12'h000;
   localparam logic [`CSR_ADDR_WIDTH-1:0] ADDR_CYCLE    = 12'hC00;
   localparam logic [`CSR_ADDR_WIDTH-1:0] ADDR_TIME     = 12'hC01;
   localparam logic [`CSR_ADDR_WIDTH-1:0] ADDR_INSTRET  = 12'hC02;
   localparam logic [`CSR_ADDR_WIDTH-1:0] ADDR_CYCLEH   = 12'hC80;
   localparam logic [`CSR_ADDR_WIDTH-1:0] ADDR_TIMEH    = 12'hC81;
   localparam logic [`CSR_ADDR_WIDTH-1:0] ADDR_INSTRETH = 12'hC82;

   // Timer prescaler is at least one bit wide.
   localparam int CSR_PRE_WIDTH = (`CSR_TIMER_DIV > 1) ? $clog2(`CSR_TIMER_DIV) : 1;
   localparam logic [CSR_PRE_WIDTH-1:0] CSR_PRE_MAX = CSR_PRE_WIDTH'(`CSR_TIMER_DIV - 1);

   // --------------------
   // Packets
   // --------------------
   typedef struct packed {
      logic                       valid;
      csr_op_e                    op;
      logic [`CSR_ADDR_WIDTH-1:0] addr;
      logic [`CSR_DATA_WIDTH-1:0] operand;
   } csr_req_t;

   typedef struct packed {
      logic                       valid;
      csr_op_e                    op;
      csr_sel_e                   sel;
      logic                       we;
      logic                       illegal;
      logic [`CSR_DATA_WIDTH-1:0] operand;
   } csr_dec_t;

   typedef struct packed {
      logic                       valid;
      logic                       illegal;
      logic [`CSR_DATA_WIDTH-1:0] rdata;
   } csr_rsp_t;

   // Counter word seen whole or as two halves.
   typedef struct packed {
      logic [`CSR_DATA_WIDTH-1:0] hi;
      logic [`CSR_DATA_WIDTH-1:0] lo;
   } csr_half_t;

   typedef union packed {
      logic [`CSR_XLEN-1:0] word;
      csr_half_t            half;
   } csr_cnt_u;

endpackage

`default_nettype wire

/* csr_cfg.svh */
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// --------------------
// Datapath widths
// --------------------

// Read and write width of one CSR.
`define CSR_DATA_WIDTH 32

// Full counter width.
`define CSR_XLEN 64

// Address field of a CSR request.
`define CSR_ADDR_WIDTH 12

// Clock cycles per timer step.
`define CSR_TIMER_DIV 4

`endif
